//--- logic/loopPkg.sv
package loopPkg;

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------
    localparam int errWidth = 16;   // Phase-error sample width.
    localparam int outWidth = 32;   // Filter output and integrator width.
    localparam int expWidth = 5;
    localparam int manWidth = 8;
    localparam int runWidth = 16;   // Lock run counter and lockCount width.
    localparam int thrWidth = 8;

    typedef logic signed [errWidth-1:0] errorT;
    typedef logic signed [outWidth-1:0] loopOutT;

    // Configuration as seen by the filter and the lock detector.
    typedef struct packed {
        logic                zeroError;
        logic                invertError;
        logic                holdIntegrator;
        logic [expWidth-1:0] leadExp;
        logic [manWidth-1:0] leadMan;
        logic [expWidth-1:0] lagExp;
        logic [manWidth-1:0] lagMan;
        loopOutT             limit;         // Output clamps to plus or minus this.
        logic [runWidth-1:0] lockCount;
        logic [thrWidth-1:0] syncThreshold;
    } loopCfgT;

endpackage

//--- logic/regMapPkg.sv
package regMapPkg;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam int regAddrWidth = 12;
    localparam int laneCount    = 4;    // Byte lanes per register word.
    localparam int laneWidth    = 8;

    typedef enum logic [regAddrWidth-1:0] {
        lfControl      = 12'h000,
        lfLeadLag      = 12'h004,
        lfLimit        = 12'h008,
        lfLoopData     = 12'h00C,
        lfLockDetector = 12'h010,
        lfStatus       = 12'h014    // Read-only.
    } regAddrT;

    // --------------------------------------------------
    // Host bridge
    // --------------------------------------------------
    typedef enum logic [1:0] {
        idle,
        access,         // One bus access happens here.
        waitReqLow
    } bridgeStateT;

endpackage

//--- logic/regBusIf.sv
`timescale 1ns/1ps

interface regBusIf #(
    parameter int addrWidth = 12,
    parameter int dataWidth = 32
);

    logic [addrWidth-1:0]   addr;
    logic [dataWidth-1:0]   wrData;
    logic [dataWidth/8-1:0] byteEn;
    logic                   wrEn;       // Single-cycle write strobe.
    logic                   rdEn;       // Single-cycle read strobe.
    logic [dataWidth-1:0]   rdData;

    modport host (
        output addr, wrData, byteEn, wrEn, rdEn,
        input  rdData
    );

    modport regs (
        input  addr, wrData, byteEn, wrEn, rdEn,
        output rdData
    );

endinterface

//--- logic/hostBridge.sv
`timescale 1ns/1ps

module hostBridge import regMapPkg::*; #(
    parameter int addrWidth = 12,
    parameter int dataWidth = 32
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           req,
    input  logic                           we,
    input  logic [addrWidth-1:0]           addr,
    input  logic [dataWidth-1:0]           wrData,
    input  logic [dataWidth/laneWidth-1:0] byteEn,
    output logic                           ack,
    output logic [dataWidth-1:0]           rdData,
    regBusIf.host                          bus
);

    bridgeStateT state;

    // Address and data are held stable by the host for the whole handshake.
    assign bus.addr   = addr;
    assign bus.wrData = wrData;
    assign bus.byteEn = byteEn;
    assign bus.wrEn   = (state == access) && we;
    assign bus.rdEn   = (state == access) && !we;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= idle;
            ack    <= 1'b0;
            rdData <= '0;
        end else begin
            ack <= (state == waitReqLow);    // Lags the state by one cycle.
            case (state)
                idle: begin
                    if (req && !ack) begin
                        state <= access;     // Previous ack must be gone first.
                    end
                end
                access: begin
                    state <= waitReqLow;
                    if (!we) begin
                        rdData <= bus.rdData;
                    end
                end
                waitReqLow: begin
                    if (!req) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

//--- logic/loopRegs.sv
`timescale 1ns/1ps

module loopRegs import loopPkg::*, regMapPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    regBusIf.regs               bus,
    input  logic                locked,
    input  logic [runWidth-1:0] lockRun,
    output loopCfgT             cfg,
    output logic                preload,
    output loopOutT             preloadValue
);

    localparam int regWidth = laneCount * laneWidth;

    loopCfgT             cfgQ;
    loopOutT             loopData;
    logic [regWidth-1:0] controlImg;
    logic [regWidth-1:0] leadLagImg;
    logic [regWidth-1:0] lockImg;
    logic [regWidth-1:0] statusImg;
    logic [regWidth-1:0] controlNew;
    logic [regWidth-1:0] leadLagNew;
    logic [regWidth-1:0] limitNew;
    logic [regWidth-1:0] loopDataNew;
    logic [regWidth-1:0] lockNew;

    function automatic logic [regWidth-1:0] mergeLanes(
        input logic [regWidth-1:0]  oldVal,
        input logic [regWidth-1:0]  newVal,
        input logic [laneCount-1:0] laneEn
    );
        logic [regWidth-1:0] result;
        result = oldVal;
        for (int i = 0; i < laneCount; i++) begin
            if (laneEn[i]) begin
                result[i*laneWidth +: laneWidth] = newVal[i*laneWidth +: laneWidth];
            end
        end
        return result;
    endfunction

    // --------------------------------------------------
    // Register images, gap bits read as zero
    // --------------------------------------------------
    assign controlImg = {29'd0, cfgQ.holdIntegrator, cfgQ.invertError, cfgQ.zeroError};
    assign leadLagImg = {cfgQ.leadMan, 3'd0, cfgQ.leadExp, cfgQ.lagMan, 3'd0, cfgQ.lagExp};
    assign lockImg    = {8'd0, cfgQ.syncThreshold, cfgQ.lockCount};
    assign statusImg  = {8'd0, lockRun, 7'd0, locked};

    assign controlNew  = mergeLanes(controlImg, bus.wrData, bus.byteEn);
    assign leadLagNew  = mergeLanes(leadLagImg, bus.wrData, bus.byteEn);
    assign limitNew    = mergeLanes(cfgQ.limit, bus.wrData, bus.byteEn);
    assign loopDataNew = mergeLanes(loopData, bus.wrData, bus.byteEn);
    assign lockNew     = mergeLanes(lockImg, bus.wrData, bus.byteEn);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfgQ     <= '0;
            loopData <= '0;
            preload  <= 1'b0;
        end else begin
            preload <= 1'b0;
            if (bus.wrEn) begin
                case (bus.addr)
                    lfControl: begin
                        cfgQ.zeroError      <= controlNew[0];
                        cfgQ.invertError    <= controlNew[1];
                        cfgQ.holdIntegrator <= controlNew[2];
                    end
                    lfLeadLag: begin
                        cfgQ.lagExp  <= leadLagNew[4:0];
                        cfgQ.lagMan  <= leadLagNew[15:8];
                        cfgQ.leadExp <= leadLagNew[20:16];
                        cfgQ.leadMan <= leadLagNew[31:24];
                    end
                    lfLimit: begin
                        cfgQ.limit <= limitNew;
                    end
                    lfLoopData: begin
                        loopData <= loopDataNew;
                        preload  <= |bus.byteEn;    // Integrator loads next cycle.
                    end
                    lfLockDetector: begin
                        cfgQ.lockCount     <= lockNew[15:0];
                        cfgQ.syncThreshold <= lockNew[23:16];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        bus.rdData = '0;
        if (bus.rdEn) begin
            case (bus.addr)
                lfControl:      bus.rdData = controlImg;
                lfLeadLag:      bus.rdData = leadLagImg;
                lfLimit:        bus.rdData = cfgQ.limit;
                lfLoopData:     bus.rdData = loopData;
                lfLockDetector: bus.rdData = lockImg;
                lfStatus:       bus.rdData = statusImg;
                default:        bus.rdData = '0;
            endcase
        end
    end

    assign cfg          = cfgQ;
    assign preloadValue = loopData;

endmodule

//--- logic/loopFilter.sv
`timescale 1ns/1ps

module loopFilter import loopPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  loopCfgT cfg,
    input  logic    preload,
    input  loopOutT preloadValue,
    input  logic    sampleValid,
    input  errorT   errorIn,
    output logic    condValid,
    output errorT   condError,
    output logic    outValid,
    output loopOutT loopOut
);

    localparam logic signed [63:0] outMax = (64'sd1 <<< (outWidth - 1)) - 64'sd1;
    localparam logic signed [63:0] outMin = -(64'sd1 <<< (outWidth - 1));
    localparam errorT errMax = {1'b0, {(errWidth-1){1'b1}}};
    localparam errorT errMin = {1'b1, {(errWidth-1){1'b0}}};

    errorT              conditioned;
    loopOutT            leadTerm;
    loopOutT            lagTerm;
    loopOutT            integ;
    loopOutT            integNext;
    loopOutT            clamped;
    logic signed [63:0] sumWide;
    logic signed [63:0] limitWide;

    function automatic loopOutT saturate(input logic signed [63:0] value);
        if (value > outMax) begin
            return loopOutT'(outMax);
        end
        if (value < outMin) begin
            return loopOutT'(outMin);
        end
        return loopOutT'(value);
    endfunction

    // Gain is an unsigned mantissa times two to the exponent.
    function automatic loopOutT scaleTerm(
        input errorT               err,
        input logic [manWidth-1:0] man,
        input logic [expWidth-1:0] exp
    );
        logic signed [63:0] wide;
        wide = err;
        wide = wide * $signed({1'b0, man});
        return saturate(wide <<< exp);
    endfunction

    // --------------------------------------------------
    // Stage 1: conditioning and gain products
    // --------------------------------------------------
    always_comb begin
        if (cfg.zeroError) begin
            conditioned = '0;
        end else if (cfg.invertError) begin
            conditioned = (errorIn == errMin) ? errMax : -errorIn;
        end else begin
            conditioned = errorIn;
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            condError <= conditioned;
            leadTerm  <= scaleTerm(conditioned, cfg.leadMan, cfg.leadExp);
            lagTerm   <= scaleTerm(conditioned, cfg.lagMan, cfg.lagExp);
        end
    end

    // --------------------------------------------------
    // Stage 2: integrator, sum and clamp
    // --------------------------------------------------
    always_comb begin
        integNext = integ;
        if (preload) begin
            integNext = preloadValue;    // Preload wins over accumulation.
        end else if (condValid && !cfg.holdIntegrator) begin
            integNext = saturate(64'(integ) + 64'(lagTerm));
        end
    end

    assign sumWide   = 64'(integNext) + 64'(leadTerm);
    assign limitWide = 64'(cfg.limit);

    always_comb begin
        if (sumWide > limitWide) begin
            clamped = cfg.limit;
        end else if (sumWide < -limitWide) begin
            clamped = -cfg.limit;
        end else begin
            clamped = loopOutT'(sumWide);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            condValid <= 1'b0;
            outValid  <= 1'b0;
            integ     <= '0;
        end else begin
            condValid <= sampleValid;
            outValid  <= condValid;
            integ     <= integNext;
        end
    end

    always_ff @(posedge clk) begin
        if (condValid) begin
            loopOut <= clamped;
        end
    end

endmodule

//--- logic/lockDetector.sv
`timescale 1ns/1ps

module lockDetector import loopPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  loopCfgT             cfg,
    input  logic                sampleValid,
    input  errorT               condError,
    output logic                locked,
    output logic [runWidth-1:0] lockRun
);

    logic [errWidth-1:0] magnitude;
    logic                inThreshold;
    logic [runWidth-1:0] runNext;

    // Unsigned result, so the most negative sample still gives its true size.
    assign magnitude   = condError[errWidth-1] ? -condError : condError;
    assign inThreshold = magnitude <= errWidth'(cfg.syncThreshold);

    always_comb begin
        if (!inThreshold) begin
            runNext = '0;
        end else if (&lockRun) begin
            runNext = lockRun;    // Saturates.
        end else begin
            runNext = lockRun + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lockRun <= '0;
            locked  <= 1'b0;
        end else if (sampleValid) begin
            lockRun <= runNext;
            locked  <= inThreshold && (cfg.lockCount != '0) && (runNext >= cfg.lockCount);
        end
    end

endmodule

//--- logic/loopTop.sv
`timescale 1ns/1ps

module loopTop import loopPkg::*; #(
    parameter int addrWidth = 12,
    parameter int dataWidth = 32
) (
    input  logic                   clk,
    input  logic                   rstN,
    // Host register port.
    input  logic                   req,
    input  logic                   we,
    input  logic [addrWidth-1:0]   addr,
    input  logic [dataWidth-1:0]   wrData,
    input  logic [dataWidth/8-1:0] byteEn,
    output logic                   ack,
    output logic [dataWidth-1:0]   rdData,
    // Sample path.
    input  logic                   sampleValid,
    input  errorT                  errorIn,
    output logic                   outValid,
    output loopOutT                loopOut,
    output logic                   locked
);

    loopCfgT             cfg;
    logic                preload;
    loopOutT             preloadValue;
    logic                condValid;
    errorT               condError;
    logic [runWidth-1:0] lockRun;

    regBusIf #(.addrWidth(addrWidth), .dataWidth(dataWidth)) regBus0 ();

    // --------------------------------------------------
    // Register side
    // --------------------------------------------------
    hostBridge #(
        .addrWidth (addrWidth),
        .dataWidth (dataWidth)
    ) bridge0 (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wrData (wrData),
        .byteEn (byteEn),
        .ack    (ack),
        .rdData (rdData),
        .bus    (regBus0.host)
    );

    loopRegs regs0 (
        .clk          (clk),
        .rstN         (rstN),
        .bus          (regBus0.regs),
        .locked       (locked),
        .lockRun      (lockRun),
        .cfg          (cfg),
        .preload      (preload),
        .preloadValue (preloadValue)
    );

    // --------------------------------------------------
    // Sample side
    // --------------------------------------------------
    loopFilter filter0 (
        .clk          (clk),
        .rstN         (rstN),
        .cfg          (cfg),
        .preload      (preload),
        .preloadValue (preloadValue),
        .sampleValid  (sampleValid),
        .errorIn      (errorIn),
        .condValid    (condValid),
        .condError    (condError),
        .outValid     (outValid),
        .loopOut      (loopOut)
    );

    lockDetector lock0 (
        .clk         (clk),
        .rstN        (rstN),
        .cfg         (cfg),
        .sampleValid (condValid),    // Lock updates alongside outValid.
        .condError   (condError),
        .locked      (locked),
        .lockRun     (lockRun)
    );

endmodule

//--- test/loopChecker.sv
`timescale 1ns/1ps

module loopChecker import loopPkg::*, regMapPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        req,
    input  logic        we,
    input  logic [11:0] addr,
    input  logic [31:0] wrData,
    input  logic [3:0]  byteEn,
    input  logic        ack,
    input  logic        sampleValid,
    input  errorT       errorIn,
    input  logic        outValid,
    input  loopOutT     loopOut,
    input  logic        locked,
    output int          errCount,
    output int          pending
);

    localparam longint outMax = 64'sd2147483647;
    localparam longint outMin = -64'sd2147483648;

    logic [31:0] ctrlReg;
    logic [31:0] leadLagReg;
    logic [31:0] limitReg;
    logic [31:0] loopDataReg;
    logic [31:0] lockReg;
    longint      integ;
    int          run;
    logic        lockFlag;
    logic        ackPrev;
    logic        valid1;
    logic        valid2;
    longint      expOut[$];
    logic        expLock[$];

    function automatic logic [31:0] laneWrite(
        input logic [31:0] old,
        input logic [31:0] din,
        input logic [3:0]  be
    );
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (din & mask);
    endfunction

    function automatic longint saturate32(input longint v);
        if (v > outMax) begin
            return outMax;
        end
        if (v < outMin) begin
            return outMin;
        end
        return v;
    endfunction

    // Gain is mantissa times two to the exponent.
    function automatic longint gainProduct(
        input longint     err,
        input logic [7:0] man,
        input logic [4:0] ex
    );
        return saturate32((err * longint'(man)) <<< ex);
    endfunction

    // --------------------------------------------------
    // Configuration copy from snooped host writes
    // --------------------------------------------------
    task automatic applyWrite();
        case (addr)
            lfControl:      ctrlReg = laneWrite(ctrlReg, wrData, byteEn);
            lfLeadLag:      leadLagReg = laneWrite(leadLagReg, wrData, byteEn);
            lfLimit:        limitReg = laneWrite(limitReg, wrData, byteEn);
            lfLockDetector: lockReg = laneWrite(lockReg, wrData, byteEn);
            lfLoopData: begin
                loopDataReg = laneWrite(loopDataReg, wrData, byteEn);
                if (|byteEn) begin
                    integ = longint'($signed(loopDataReg));    // Integrator restarts here.
                end
            end
            default: ;
        endcase
    endtask

    task automatic modelSample(input errorT e);
        longint cond;
        longint lead;
        longint lag;
        longint sum;
        longint lim;
        longint mag;
        if (ctrlReg[0]) begin
            cond = 0;
        end else if (ctrlReg[1]) begin
            cond = (e == errorT'(16'h8000)) ? 32767 : -longint'(e);
        end else begin
            cond = longint'(e);
        end
        lead = gainProduct(cond, leadLagReg[31:24], leadLagReg[20:16]);
        lag  = gainProduct(cond, leadLagReg[15:8], leadLagReg[4:0]);
        if (!ctrlReg[2]) begin
            integ = saturate32(integ + lag);
        end
        sum = integ + lead;
        lim = longint'($signed(limitReg));
        if (sum > lim) begin
            sum = lim;
        end else if (sum < -lim) begin
            sum = -lim;
        end
        mag = (cond < 0) ? -cond : cond;
        if (mag <= longint'(lockReg[23:16])) begin
            if (run < 65535) begin
                run++;
            end
            lockFlag = (lockReg[15:0] != 16'd0) && (run >= int'(lockReg[15:0]));
        end else begin
            run      = 0;
            lockFlag = 1'b0;
        end
        expOut.push_back(sum);
        expLock.push_back(lockFlag);
    endtask

    task automatic checkOutput();
        longint wantOut;
        logic   wantLock;
        if (expOut.size() == 0) begin
            errCount++;
            $display("ERR %0t: outValid with no sample in flight", $time);
        end else begin
            wantOut  = expOut.pop_front();
            wantLock = expLock.pop_front();
            if (loopOut !== loopOutT'(wantOut)) begin
                errCount++;
                $display("ERR %0t: loopOut is %0d, expected %0d", $time, loopOut, wantOut);
            end
            if (locked !== wantLock) begin
                errCount++;
                $display("ERR %0t: locked is %b, expected %b", $time, locked, wantLock);
            end
        end
    endtask

    initial begin
        errCount = 0;
        pending  = 0;
    end

    // Sampled at the falling edge, where every DUT signal is settled.
    always @(negedge clk) begin
        if (!rstN) begin
            ctrlReg     = '0;
            leadLagReg  = '0;
            limitReg    = '0;
            loopDataReg = '0;
            lockReg     = '0;
            integ       = 0;
            run         = 0;
            lockFlag    = 1'b0;
            ackPrev     = 1'b0;
            valid1      = 1'b0;
            valid2      = 1'b0;
            expOut.delete();
            expLock.delete();
        end else begin
            if (ack && !ackPrev && req && we) begin
                applyWrite();
            end
            ackPrev = ack;
            if (outValid !== valid2) begin
                errCount++;
                $display("ERR %0t: outValid is %b, expected %b", $time, outValid, valid2);
            end
            if (outValid) begin
                checkOutput();
            end
            valid2 = valid1;    // Two cycles from sampleValid to outValid.
            valid1 = sampleValid;
            if (sampleValid) begin
                modelSample(errorIn);
            end
        end
        pending = expOut.size();
    end

endmodule

//--- test/loopTb.sv
`timescale 1ns/1ps

module loopTb import loopPkg::*; ();

    localparam int clkPeriod     = 8;
    localparam int resetCycles   = 2;
    localparam int randomCount   = 60;
    localparam int heldWrites    = 1;
    localparam int cyclesPerLine = 10;
    localparam int ackLatency    = 2;    // Cycles from req sampled high to ack high.
    localparam int holdCycles    = 3;

    logic        clk;
    logic        rstN;
    logic        req;
    logic        we;
    logic [11:0] addr;
    logic [31:0] wrData;
    logic [3:0]  byteEn;
    logic        ack;
    logic [31:0] rdData;
    logic        sampleValid;
    errorT       errorIn;
    logic        outValid;
    loopOutT     loopOut;
    logic        locked;

    int          readErrors  = 0;
    int          shakeErrors = 0;
    int          otherErrors = 0;
    int          checkErrors;
    int          checkPending;
    longint      watchdogNs  = 0;
    string       lines[$];

    loopTop dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wrData      (wrData),
        .byteEn      (byteEn),
        .ack         (ack),
        .rdData      (rdData),
        .sampleValid (sampleValid),
        .errorIn     (errorIn),
        .outValid    (outValid),
        .loopOut     (loopOut),
        .locked      (locked)
    );

    loopChecker checker0 (
        .clk         (clk),
        .rstN        (rstN),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wrData      (wrData),
        .byteEn      (byteEn),
        .ack         (ack),
        .sampleValid (sampleValid),
        .errorIn     (errorIn),
        .outValid    (outValid),
        .loopOut     (loopOut),
        .locked      (locked),
        .errCount    (checkErrors),
        .pending     (checkPending)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        wait (watchdogNs != 0);
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns", watchdogNs);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------------------------------------
    // Four-phase host access
    // --------------------------------------------------
    task automatic hostAccess(
        input  logic        isWrite,
        input  logic [11:0] a,
        input  logic [31:0] d,
        input  logic [3:0]  be,
        input  logic        streamSamples,
        output logic [31:0] rd
    );
        int waited;
        @(posedge clk);
        sampleValid <= 1'b0;
        req         <= 1'b1;
        we          <= isWrite;
        addr        <= a;
        wrData      <= d;
        byteEn      <= be;
        @(posedge clk);    // The bridge sees req here.
        waited = 0;
        @(negedge clk);
        while (!ack) begin
            waited++;
            @(negedge clk);
        end
        if (waited != ackLatency) begin
            shakeErrors++;
            $display("ERR %0t: ack came %0d cycles after req, expected %0d",
                     $time, waited, ackLatency);
        end
        rd = rdData;
        repeat (holdCycles) begin
            @(posedge clk);
            if (streamSamples) begin
                sampleValid <= 1'b1;    // A repeated write would disturb these samples.
                errorIn     <= errorT'(16'sd3);
            end
            @(negedge clk);
            if (!ack) begin
                shakeErrors++;
                $display("ERR %0t: ack dropped while req was held", $time);
            end
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        req         <= 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic driveSample(input errorT e);
        @(posedge clk);
        sampleValid <= 1'b1;
        errorIn     <= e;
    endtask

    initial begin
        int          fd;
        int          n;
        string       cur;
        string       rest;
        byte         op;
        logic [11:0] a;
        logic [31:0] d;
        logic [3:0]  be;
        logic [31:0] rd;
        logic [31:0] rng;
        rstN        = 1'b0;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wrData      = '0;
        byteEn      = '0;
        sampleValid = 1'b0;
        errorIn     = '0;
        rng         = 32'd71248;

        fd = $fopen("test/loopInput.dat", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Could not open the stimulus file test/loopInput.dat");
        end else begin
            while (!$feof(fd)) begin
                cur = "";
                n = $fgets(cur, fd);
                if (n > 0 && cur.len() > 2 && cur[0] != "#") begin
                    lines.push_back(cur);
                end
            end
            $fclose(fd);
        end
        watchdogNs = longint'(lines.size() + heldWrites + randomCount)
                     * cyclesPerLine * clkPeriod;

        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        foreach (lines[i]) begin
            cur  = lines[i];
            op   = cur[0];
            rest = cur.substr(2, cur.len() - 1);
            case (op)
                "W": begin
                    n = $sscanf(rest, "%h %h %h", a, d, be);
                    hostAccess(1'b1, a, d, be, 1'b0, rd);
                end
                "R": begin
                    n = $sscanf(rest, "%h %h", a, d);
                    hostAccess(1'b0, a, 32'd0, 4'hf, 1'b0, rd);
                    if (rd !== d) begin
                        readErrors++;
                        $display("ERR %0t: read of %03h returned %08h, expected %08h",
                                 $time, a, rd, d);
                    end
                end
                "S": begin
                    n = $sscanf(rest, "%h", d);
                    driveSample(errorT'(d[15:0]));
                end
                default: begin
                    n = 0;
                end
            endcase
            if (n == 0) begin
                otherErrors++;
                $display("Stimulus line could not be parsed: %s", cur);
            end
        end

        // --------------------------------------------------
        // Random small errors, with idle gaps
        // --------------------------------------------------
        repeat (randomCount) begin
            rng = nextRandom(rng);
            @(posedge clk);
            sampleValid <= rng[8];
            errorIn     <= errorT'(int'(rng % 9) - 4);
        end
        @(posedge clk);
        sampleValid <= 1'b0;

        // The integrator must restart once, even though req stays high for several cycles.
        repeat (heldWrites) begin
            hostAccess(1'b1, 12'h00C, 32'h0000_0040, 4'hf, 1'b1, rd);
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        if (checkPending != 0) begin
            otherErrors++;
            $display("%0d filter outputs never appeared", checkPending);
        end

        $display("Errors: read %0d, handshake %0d, checker %0d, other %0d",
                 readErrors, shakeErrors, checkErrors, otherErrors);
        if (readErrors + shakeErrors + checkErrors + otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- test/loopInput.dat
# Columns: W addr data byteEn | R addr expected | S error; all fields hex.
# Errors are 16-bit two's complement samples.
W 004 11223344 f
R 004 11023304
W 004 aabbccdd 2
R 004 1102cc04
W 008 7fffffff 3
R 008 0000ffff
R 018 00000000
W 004 03020000 f
W 008 00001000 f
S 0064
S ff9c
S 0200
W 004 00000102 f
W 008 7fffffff f
S 000a
S 000a
W 000 00000004 1
R 000 00000004
S 000a
W 00c 00000100 f
R 00c 00000100
W 000 00000000 1
S 000a
W 000 00000001 1
S 0005
W 000 00000002 1
S 0005
W 010 00030004 f
R 010 00030004
S 0001
S fffe
S 0003
S 0002
R 014 00000401
S 0009
R 014 00000000

//--- verilog.f
logic/loopPkg.sv
logic/regMapPkg.sv
logic/regBusIf.sv
logic/hostBridge.sv
logic/loopRegs.sv
logic/loopFilter.sv
logic/lockDetector.sv
logic/loopTop.sv
test/loopChecker.sv
test/loopTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module loopTb -f verilog.f -o loopSim
./obj_dir/loopSim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
